// File: hdl/mulCtrlPkg.sv
package mulCtrlPkg;

    // Sequencer states, one add/sub step and one shift step per multiplier bit
    typedef enum logic [1:0]
    {
        Idle,   // Waiting for Start
        Arith,  // Add, subtract or hold on X:A
        Shift   // Arithmetic right shift of X:A:B
    } seqState_t;

    // Datapath operations issued each cycle
    typedef enum logic [2:0]
    {
        OpHold,   // Registers keep their value
        OpLoad,   // S and B from the request, X:A cleared
        OpAdd,    // X:A <- A + S
        OpSub,    // X:A <- A - S, only on the sign bit of the multiplier
        OpShift   // X:A:B >>> 1
    } dpOp_t;

    // Control word from the sequencer to the datapath
    typedef struct packed
    {
        dpOp_t op;
        logic  last;  // Final shift of the multiplication
    } ctrlWord_t;

    // Control word with nothing happening
    localparam ctrlWord_t CtrlIdle = '{op: OpHold, last: 1'b0};

endpackage

// File: hdl/mulDataPkg.sv
package mulDataPkg;

    // Operand width used by the top level
    localparam int DefaultWidth = 8;

    // Start payload, both operands two's complement
    typedef struct packed
    {
        logic signed [DefaultWidth-1:0] multiplicand;
        logic signed [DefaultWidth-1:0] multiplier;
    } mulReq_t;

    // Done payload
    typedef struct packed
    {
        logic signed [2*DefaultWidth-1:0] product;  // Full signed product
    } mulResult_t;

endpackage

// File: hdl/addSubUnit.sv
`timescale 1ns/1ns

module addSubUnit
#(
    parameter int Width = 8
)
(
    input  logic [Width-1:0]      A,
    input  logic [Width-1:0]      S,
    input  mulCtrlPkg::ctrlWord_t Ctrl,
    output logic [Width:0]        Sum  // New X in the top bit, new A below
);

    logic [Width:0] aExt;
    logic [Width:0] sExt;
    logic [Width:0] operand;
    logic           isSub;

    // One extra bit so the sign survives an overflow of A
    assign aExt = {A[Width-1], A};
    assign sExt = {S[Width-1], S};

    assign isSub = (Ctrl.op == mulCtrlPkg::OpSub);

    // Subtract as invert plus carry in
    assign operand = isSub ? ~sExt : sExt;

    assign Sum = aExt + operand + (Width+1)'(isSub);

endmodule

// File: hdl/mulRegisters.sv
`timescale 1ns/1ns

module mulRegisters
#(
    parameter int Width = 8
)
(
    input  logic                   Clk,
    input  logic                   rst,
    input  mulDataPkg::mulReq_t    Req,
    input  mulCtrlPkg::ctrlWord_t  Ctrl,
    input  logic [Width:0]         Sum,     // From the adder, {X, A}
    output logic [Width-1:0]       A,
    output logic [Width-1:0]       S,
    output logic                   M,
    output logic                   Done,
    output mulDataPkg::mulResult_t Result
);

    localparam int ProdWidth = $bits(mulDataPkg::mulResult_t);

    logic             X;       // Sign extension of the partial product
    logic [Width-1:0] B;       // Multiplier, shifted out as the product fills in
    logic [Width-1:0] shiftA;
    logic [Width-1:0] shiftB;

    // X:A:B one place to the right, X copied into itself
    assign shiftA = {X, A[Width-1:1]};
    assign shiftB = {A[0], B[Width-1:1]};

    always_ff @(posedge Clk)
    begin
        unique case (Ctrl.op)
            mulCtrlPkg::OpLoad:
            begin
                X <= 1'b0;
                A <= '0;
                S <= Width'(Req.multiplicand);
                B <= Width'(Req.multiplier);
            end

            mulCtrlPkg::OpAdd,
            mulCtrlPkg::OpSub:
            begin
                {X, A} <= Sum;
            end

            mulCtrlPkg::OpShift:
            begin
                A <= shiftA;
                B <= shiftB;
            end

            default:
            begin
                // OpHold keeps everything
            end
        endcase
    end

    // Product and strobe on the final shift
    always_ff @(posedge Clk)
    begin
        if (rst)
        begin
            Done   <= 1'b0;
            Result <= '0;
        end
        else
        begin
            Done <= 1'b0;
            if (Ctrl.op == mulCtrlPkg::OpShift && Ctrl.last)
            begin
                Done           <= 1'b1;
                Result.product <= ProdWidth'(signed'({shiftA, shiftB}));
            end
        end
    end

    assign M = B[0];

endmodule

// File: hdl/mulSequencer.sv
`timescale 1ns/1ns

module mulSequencer
#(
    parameter int Width = 8
)
(
    input  logic                  Clk,
    input  logic                  rst,
    input  logic                  Start,  // Single-cycle strobe
    input  logic                  M,      // Low bit of register B
    output mulCtrlPkg::ctrlWord_t Ctrl,
    output logic                  Busy
);

    localparam int CntWidth = $clog2(Width);

    mulCtrlPkg::seqState_t state;
    mulCtrlPkg::seqState_t nextState;
    logic [CntWidth-1:0]   round;      // Multiplier bit being processed
    logic [CntWidth-1:0]   nextRound;
    logic                  lastRound;

    // Sign bit of the multiplier is the last round
    assign lastRound = (round == CntWidth'(Width - 1));

    always_ff @(posedge Clk)
    begin
        if (rst)
        begin
            state <= mulCtrlPkg::Idle;
            round <= '0;
        end
        else
        begin
            state <= nextState;
            round <= nextRound;
        end
    end

    always_comb
    begin
        nextState = state;
        nextRound = round;
        Ctrl      = mulCtrlPkg::CtrlIdle;

        unique case (state)
            mulCtrlPkg::Idle:
            begin
                // Load happens on the same edge that samples Start
                if (Start)
                begin
                    Ctrl.op   = mulCtrlPkg::OpLoad;
                    nextState = mulCtrlPkg::Arith;
                    nextRound = '0;
                end
            end

            mulCtrlPkg::Arith:
            begin
                // M picks between add and hold
                if (M)
                begin
                    if (lastRound)
                        Ctrl.op = mulCtrlPkg::OpSub;  // Negative weight of the sign bit
                    else
                        Ctrl.op = mulCtrlPkg::OpAdd;
                end
                nextState = mulCtrlPkg::Shift;
            end

            mulCtrlPkg::Shift:
            begin
                Ctrl.op   = mulCtrlPkg::OpShift;
                Ctrl.last = lastRound;
                if (lastRound)
                begin
                    nextState = mulCtrlPkg::Idle;
                    nextRound = '0;
                end
                else
                begin
                    nextState = mulCtrlPkg::Arith;
                    nextRound = round + 1'b1;
                end
            end

            default:
            begin
                nextState = mulCtrlPkg::Idle;  // Recover from an unused encoding
                nextRound = '0;
            end
        endcase
    end

    // Low again in the Done cycle, so a new Start is taken there
    assign Busy = (state != mulCtrlPkg::Idle);

endmodule

// File: hdl/multiplierTop.sv
`timescale 1ns/1ns

module multiplierTop
#(
    parameter int Width = mulDataPkg::DefaultWidth
)
(
    input  logic                   Clk,
    input  logic                   rst,
    input  logic                   Start,
    input  mulDataPkg::mulReq_t    Req,
    output logic                   Done,
    output mulDataPkg::mulResult_t Result,
    output logic                   Busy
);

    mulCtrlPkg::ctrlWord_t Ctrl;
    logic                  M;
    logic [Width-1:0]      A;
    logic [Width-1:0]      S;
    logic [Width:0]        Sum;

    mulSequencer #(.Width(Width)) sequencer
    (
        .Clk   (Clk),
        .rst   (rst),
        .Start (Start),
        .M     (M),
        .Ctrl  (Ctrl),
        .Busy  (Busy)
    );

    addSubUnit #(.Width(Width)) adder
    (
        .A    (A),
        .S    (S),
        .Ctrl (Ctrl),
        .Sum  (Sum)
    );

    mulRegisters #(.Width(Width)) registers
    (
        .Clk    (Clk),
        .rst    (rst),
        .Req    (Req),
        .Ctrl   (Ctrl),
        .Sum    (Sum),
        .A      (A),
        .S      (S),
        .M      (M),
        .Done   (Done),
        .Result (Result)
    );

endmodule

// File: tb/tbClock.sv
`timescale 1ns/1ns

module tbClock
#(
    parameter int Period = 20  // ns
)
(
    output logic Clk
);

    initial
    begin
        Clk = 1'b0;
        forever #(Period / 2) Clk = ~Clk;
    end

endmodule

// File: tb/mulSeq_props.sv
`timescale 1ns/1ns

module mulSeqProps
#(
    parameter int Width = 8
)
(
    input logic                  Clk,
    input logic                  rst,
    input mulCtrlPkg::seqState_t state,
    input mulCtrlPkg::ctrlWord_t Ctrl,
    input logic                  Busy
);

    int failCount = 0;  // Read by the testbench at the end of the run

    // Busy drops only after the final shift
    busyUntilLast: assert property (@(posedge Clk) disable iff (rst)
        Busy && !Ctrl.last |=> Busy)
    else
    begin
        failCount = failCount + 1;
        $error("Busy fell before the final shift of the multiplication");
    end

    // Width pairs of Arith and Shift between the load and the final shift
    loadToLast: assert property (@(posedge Clk) disable iff (rst)
        Ctrl.op == mulCtrlPkg::OpLoad |-> ##(2*Width)
            (Ctrl.op == mulCtrlPkg::OpShift && Ctrl.last))
    else
    begin
        failCount = failCount + 1;
        $error("Final shift did not come two cycles per multiplier bit after the load");
    end

    lastReturnsIdle: assert property (@(posedge Clk) disable iff (rst)
        Ctrl.last |=> state == mulCtrlPkg::Idle)
    else
    begin
        failCount = failCount + 1;
        $error("Sequencer did not return to Idle after the final shift");
    end

endmodule

bind mulSequencer mulSeqProps #(.Width(Width)) seqProps
(
    .Clk   (Clk),
    .rst   (rst),
    .state (state),
    .Ctrl  (Ctrl),
    .Busy  (Busy)
);

// File: tb/mulChecker.sv
`timescale 1ns/1ns

module mulChecker
#(
    parameter int Width = 8
)
(
    input  logic                   Clk,
    input  logic                   rst,
    input  logic                   Start,
    input  mulDataPkg::mulReq_t    Req,
    input  logic                   Done,
    input  mulDataPkg::mulResult_t Result,
    input  logic                   Busy,
    input  int                     testId,   // Group that issued the Start
    output int                     mismatchCount,
    output int                     otherCount,
    output int                     resultCount
);

    localparam int ProdWidth = 2 * Width;
    localparam int Latency   = 2 * Width + 1;  // Edges from Start sample to Done sample

    mulDataPkg::mulReq_t         reqQueue[$];
    int                          startQueue[$];
    int                          testQueue[$];
    int                          cycle;
    int                          latency;
    int                          doneTest;
    mulDataPkg::mulReq_t         doneReq;
    logic signed [ProdWidth-1:0] expected;
    logic signed [ProdWidth-1:0] heldResult;  // Last product seen on Done

    function automatic string testName(input int id);
        case (id)
            1:       return "corner";
            2:       return "random";
            3:       return "busyRestart";
            4:       return "idle";
            default: return "unknown";
        endcase
    endfunction

    // All inputs sampled on the rising edge, before the DUT updates
    always @(posedge Clk)
    begin
        if (rst)
        begin
            reqQueue.delete();
            startQueue.delete();
            testQueue.delete();
            cycle         = 0;
            heldResult    = '0;  // Result resets to zero
            mismatchCount = 0;
            otherCount    = 0;
            resultCount   = 0;
        end
        else
        begin
            if (Done)
            begin
                if (reqQueue.size() == 0)
                begin
                    otherCount++;
                    $display("Done strobe seen with no multiplication outstanding");
                end
                else
                begin
                    doneReq  = reqQueue.pop_front();
                    doneTest = testQueue.pop_front();
                    latency  = cycle - startQueue.pop_front();
                    // Signed model product
                    expected = ProdWidth'(doneReq.multiplicand) * ProdWidth'(doneReq.multiplier);
                    if (Result.product !== expected)
                    begin
                        mismatchCount++;
                        $display("mismatch %s: expected %0d, actual %0d",
                                 testName(doneTest), expected, Result.product);
                    end
                    if (latency != Latency)
                    begin
                        mismatchCount++;
                        $display("mismatch %s latency: expected %0d, actual %0d",
                                 testName(doneTest), Latency, latency);
                    end
                    resultCount++;
                end
                if (Busy)
                begin
                    otherCount++;
                    $display("Busy still high in the Done cycle");
                end
                heldResult = Result.product;
            end
            else if (Result.product !== heldResult)
            begin
                mismatchCount++;
                $display("mismatch %s held result: expected %0d, actual %0d",
                         testName(testId), heldResult, Result.product);
            end

            // Busy follows the multiplication in flight
            if (!Done && Busy !== (reqQueue.size() != 0))
            begin
                otherCount++;
                $display("Busy does not match whether a multiplication is in progress");
            end

            if (Start && !Busy)  // Accepted Start only
            begin
                reqQueue.push_back(Req);
                startQueue.push_back(cycle);
                testQueue.push_back(testId);
            end
            cycle++;
        end
    end

endmodule

// File: tb/multiplierTb.sv
`timescale 1ns/1ns

module multiplierTb;

    localparam int          Width       = mulDataPkg::DefaultWidth;
    localparam int          ResetCycles = 8;
    localparam int          RandomTests = 400;
    localparam int          NumTests    = 25 + RandomTests + 2;
    localparam int          DoneLimit   = 4 * Width;  // Cycles to wait for Done
    localparam longint      TimeoutNs   = (NumTests * 20 + 200) * 20;
    localparam logic [31:0] Seed        = 32'd99138;
    localparam logic [31:0] LfsrTaps    = 32'h80200003;

    logic                   Clk;
    logic                   rst;
    logic                   Start;
    mulDataPkg::mulReq_t    Req;
    logic                   Done;
    mulDataPkg::mulResult_t Result;
    logic                   Busy;
    int                     testId;

    int               mismatchCount;
    int               otherCount;
    int               resultCount;
    int               expectedResults;
    int               stimErrors;
    int               totalErrors;
    logic [31:0]      lfsrState;
    logic [Width-1:0] corner [5];
    logic [Width-1:0] opA;
    logic [Width-1:0] opB;

    tbClock #(.Period(20)) clockGen (.Clk(Clk));

    multiplierTop #(.Width(Width)) UUT
    (
        .Clk    (Clk),
        .rst    (rst),
        .Start  (Start),
        .Req    (Req),
        .Done   (Done),
        .Result (Result),
        .Busy   (Busy)
    );

    mulChecker #(.Width(Width)) resultCheck
    (
        .Clk           (Clk),
        .rst           (rst),
        .Start         (Start),
        .Req           (Req),
        .Done          (Done),
        .Result        (Result),
        .Busy          (Busy),
        .testId        (testId),
        .mismatchCount (mismatchCount),
        .otherCount    (otherCount),
        .resultCount   (resultCount)
    );

    // Galois step, output bit is the old bit 0
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LfsrTaps) : (s >> 1);
    endfunction

    task automatic randomOperand(output logic [Width-1:0] value);
        value = '0;
        for (int i = 0; i < Width; i++)
        begin
            value     = {value[Width-2:0], lfsrState[0]};
            lfsrState = lfsrStep(lfsrState);
        end
    endtask

    function automatic mulDataPkg::mulReq_t makeReq(input logic [Width-1:0] a,
                                                    input logic [Width-1:0] b);
        mulDataPkg::mulReq_t r;
        r.multiplicand = a;
        r.multiplier   = b;
        return r;
    endfunction

    // Called on a falling edge, returns on the falling edge inside the Done cycle
    task automatic waitForDone();
        int waited;
        waited = 0;
        while (!Done && waited < DoneLimit)
        begin
            @(negedge Clk);
            waited++;
        end
        if (!Done)
        begin
            stimErrors++;
            $display("No Done within %0d cycles of Start", DoneLimit);
        end
    endtask

    task automatic runOne(input mulDataPkg::mulReq_t req);
        Start = 1'b1;
        Req   = req;
        expectedResults++;
        @(negedge Clk);
        Start = 1'b0;
        waitForDone();
    endtask

    // Second Start lands while Busy and must be dropped
    task automatic runWithExtraStart(input mulDataPkg::mulReq_t req,
                                     input mulDataPkg::mulReq_t extra,
                                     input int delay);
        Start = 1'b1;
        Req   = req;
        expectedResults++;
        @(negedge Clk);
        Start = 1'b0;
        Req   = extra;
        repeat (delay) @(negedge Clk);
        Start = 1'b1;
        @(negedge Clk);
        Start = 1'b0;
        waitForDone();
    endtask

    initial
    begin
        #(TimeoutNs);
        $display("Timeout: run did not finish within %0d ns", TimeoutNs);
        $display("Finished with errors");
        $finish;
    end

    initial
    begin
        rst             = 1'b1;
        Start           = 1'b0;
        Req             = '0;
        testId          = 0;
        expectedResults = 0;
        stimErrors      = 0;
        lfsrState       = Seed;
        corner[0]       = '0;
        corner[1]       = Width'(1);
        corner[2]       = '1;                           // -1
        corner[3]       = {1'b0, {(Width-1){1'b1}}};    // Largest positive
        corner[4]       = {1'b1, {(Width-1){1'b0}}};    // Most negative

        repeat (ResetCycles) @(negedge Clk);
        rst    = 1'b0;
        testId = 4;
        repeat (5) @(negedge Clk);

        testId = 1;
        for (int i = 0; i < 5; i++)
        begin
            for (int j = 0; j < 5; j++)
                runOne(makeReq(corner[i], corner[j]));
        end

        testId = 2;
        for (int i = 0; i < RandomTests; i++)
        begin
            randomOperand(opA);
            randomOperand(opB);
            runOne(makeReq(opA, opB));
        end

        testId = 3;
        runWithExtraStart(makeReq(corner[4], Width'(3)), makeReq(Width'(5), Width'(7)), 2);
        runWithExtraStart(makeReq(Width'(9), corner[2]), makeReq(corner[3], corner[3]), 15);
        repeat (10) @(negedge Clk);

        testId = 4;
        repeat (5) @(negedge Clk);

        if (resultCount != expectedResults)
        begin
            stimErrors++;
            $display("Expected %0d results but the checker saw %0d",
                     expectedResults, resultCount);
        end
        totalErrors = mismatchCount + otherCount + stimErrors
                    + UUT.sequencer.seqProps.failCount;
        $display("Error counts: %0d mismatch, %0d protocol, %0d stimulus, %0d assertion",
                 mismatchCount, otherCount, stimErrors, UUT.sequencer.seqProps.failCount);
        if (totalErrors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

// File: flist.f
hdl/mulCtrlPkg.sv
hdl/mulDataPkg.sv
hdl/addSubUnit.sv
hdl/mulRegisters.sv
hdl/mulSequencer.sv
hdl/multiplierTop.sv
tb/tbClock.sv
tb/mulSeq_props.sv
tb/mulChecker.sv
tb/multiplierTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build with Verilator, run, and decide the result from the pass message
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -f flist.f \
        --top-module multiplierTb --Mdir obj_dir \
    && ./obj_dir/VmultiplierTb +verilator+error+limit+1000 \
        | tee /dev/stderr | grep -qx "Finished with no errors" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
